//--- mipsPkg.sv
`default_nettype none

package mipsPkg;

    //////////////////////////////////////////////////////////////////////
    // widths with a meaning

    typedef logic [31:0] wordT;
    typedef logic [29:0] wordAddrT;
    typedef logic [4:0]  regAddrT;
    typedef logic [2:0]  aluCtrlT;
    typedef logic [1:0]  fwdSelT;

    localparam int regCount = 32;

    //////////////////////////////////////////////////////////////////////
    // instruction encodings

    localparam logic [5:0] opRType = 6'h00;
    localparam logic [5:0] opJ     = 6'h02;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] opAddi  = 6'h08;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;

    // R-type function field
    localparam logic [5:0] fnAdd = 6'h20;
    localparam logic [5:0] fnSub = 6'h22;
    localparam logic [5:0] fnAnd = 6'h24;
    localparam logic [5:0] fnOr  = 6'h25;
    localparam logic [5:0] fnSlt = 6'h2a;

    // alu operations
    localparam aluCtrlT aluAnd = 3'b000;
    localparam aluCtrlT aluOr  = 3'b001;
    localparam aluCtrlT aluAdd = 3'b010;
    localparam aluCtrlT aluSub = 3'b110;
    localparam aluCtrlT aluSlt = 3'b111;

    // bypass source for an execute operand
    localparam fwdSelT fwdNone = 2'd0;
    localparam fwdSelT fwdMem  = 2'd1;
    localparam fwdSelT fwdWb   = 2'd2;

    //////////////////////////////////////////////////////////////////////
    // decoded controls and pipeline registers

    typedef struct packed {
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    branch;
        logic    aluSrcImm;
        logic    regDstRd;
        aluCtrlT aluCtrl;
    } ctrlT;

    typedef struct packed {
        wordT instr;
        wordT pcPlus4;
    } ifIdT;

    typedef struct packed {
        ctrlT    ctrl;
        wordT    pcPlus4;
        wordT    rsData;
        wordT    rtData;
        wordT    immExt;
        regAddrT rs;
        regAddrT rt;
        regAddrT wsel;
    } idExT;

    typedef struct packed {
        logic    regWrite;
        logic    memRead;
        logic    memWrite;
        logic    branch;
        logic    zero;
        wordT    aluOut;
        wordT    storeData;
        wordT    branchTarget;
        regAddrT wsel;
    } exMemT;

    typedef struct packed {
        logic    regWrite;
        logic    memRead;
        wordT    aluOut;
        wordT    loadData;
        regAddrT wsel;
    } memWbT;

    typedef struct packed {
        logic     ren;
        logic     wen;
        wordAddrT addr;
        wordT     wdata;
    } cacheReqT;

endpackage

`default_nettype wire

//--- instrDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecoder (
    input  wire mipsPkg::wordT instr,
    output mipsPkg::ctrlT      ctrl,
    output logic               jump
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instr[31:26];
    assign funct  = instr[5:0];

    always_comb begin
        // anything not listed below is a no-op
        ctrl = '0;
        jump = 1'b0;
        case (opcode)
            mipsPkg::opRType: begin
                ctrl.regWrite = 1'b1;
                ctrl.regDstRd = 1'b1;
                case (funct)
                    mipsPkg::fnAdd: ctrl.aluCtrl = mipsPkg::aluAdd;
                    mipsPkg::fnSub: ctrl.aluCtrl = mipsPkg::aluSub;
                    mipsPkg::fnAnd: ctrl.aluCtrl = mipsPkg::aluAnd;
                    mipsPkg::fnOr:  ctrl.aluCtrl = mipsPkg::aluOr;
                    mipsPkg::fnSlt: ctrl.aluCtrl = mipsPkg::aluSlt;
                    // also covers the all-zero word of a squashed slot
                    default:        ctrl = '0;
                endcase
            end
            mipsPkg::opAddi: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluCtrl   = mipsPkg::aluAdd;
            end
            mipsPkg::opLw: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluCtrl   = mipsPkg::aluAdd;
            end
            mipsPkg::opSw: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluCtrl   = mipsPkg::aluAdd;
            end
            mipsPkg::opBeq: begin
                // equality through a zero difference
                ctrl.branch  = 1'b1;
                ctrl.aluCtrl = mipsPkg::aluSub;
            end
            mipsPkg::opJ: begin
                jump = 1'b1;
            end
            default: begin
                ctrl = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- registerFile.sv
`timescale 1ns/10ps
`default_nettype none

module registerFile (
    input  wire                   clk,
    input  wire                   rst_n,
    input  wire                   wen,
    input  wire mipsPkg::regAddrT waddr,
    input  wire mipsPkg::wordT    wdata,
    input  wire mipsPkg::regAddrT raddrA,
    input  wire mipsPkg::regAddrT raddrB,
    output mipsPkg::wordT         rdataA,
    output mipsPkg::wordT         rdataB
);

    mipsPkg::wordT regs [mipsPkg::regCount];

    // r0 is hardwired, a write in flight is visible at once
    function automatic mipsPkg::wordT readReg(input mipsPkg::regAddrT addr);
        if (addr == '0) begin
            return '0;
        end else if (wen && waddr == addr) begin
            return wdata;
        end
        return regs[addr];
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < mipsPkg::regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    always_comb begin
        rdataA = readReg(raddrA);
        rdataB = readReg(raddrB);
    end

endmodule

`default_nettype wire

//--- alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu (
    input  wire mipsPkg::aluCtrlT aluCtrl,
    input  wire mipsPkg::wordT    a,
    input  wire mipsPkg::wordT    b,
    output mipsPkg::wordT         result,
    output logic                  zero
);

    mipsPkg::wordT diff;
    logic          lessThan;

    assign diff = a - b;

    // signed compare, overflow-safe
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (aluCtrl)
            mipsPkg::aluAdd: result = a + b;
            mipsPkg::aluSub: result = diff;
            mipsPkg::aluAnd: result = a & b;
            mipsPkg::aluOr:  result = a | b;
            mipsPkg::aluSlt: result = {31'd0, lessThan};
            default:         result = '0;
        endcase
    end

    // beq looks at this through the exMem register
    assign zero = (result == '0);

endmodule

`default_nettype wire

//--- hazardUnit.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnit (
    input  wire mipsPkg::ifIdT ifId,
    input  wire mipsPkg::idExT idEx,
    input  wire                jump,
    input  wire                exBranch,
    input  wire                exZero,
    input  wire                icacheStall,
    input  wire                dcacheStall,
    output logic               freeze,
    output logic               pcHold,
    output logic               ifIdHold,
    output logic               ifIdFlush,
    output logic               idExBubble,
    output logic               exMemFlush,
    output logic               branchTaken
);

    mipsPkg::regAddrT ifIdRs;
    mipsPkg::regAddrT ifIdRt;
    logic             loadUse;

    assign ifIdRs = ifId.instr[25:21];
    assign ifIdRt = ifId.instr[20:16];

    // load in execute feeding the instruction in decode
    assign loadUse = idEx.ctrl.memRead && (idEx.wsel != '0)
                     && (idEx.wsel == ifIdRs || idEx.wsel == ifIdRt);

    assign freeze      = icacheStall | dcacheStall;
    assign branchTaken = exBranch & exZero;

    always_comb begin
        pcHold     = 1'b0;
        ifIdHold   = 1'b0;
        ifIdFlush  = 1'b0;
        idExBubble = 1'b0;
        exMemFlush = 1'b0;
        if (freeze) begin
            pcHold   = 1'b1;
            ifIdHold = 1'b1;
        end else if (branchTaken) begin
            // kill the three younger slots
            ifIdFlush  = 1'b1;
            idExBubble = 1'b1;
            exMemFlush = 1'b1;
        end else if (jump) begin
            ifIdFlush = 1'b1;
        end else if (loadUse) begin
            pcHold     = 1'b1;
            ifIdHold   = 1'b1;
            idExBubble = 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- forwardUnit.sv
`timescale 1ns/10ps
`default_nettype none

module forwardUnit (
    input  wire mipsPkg::regAddrT rs,
    input  wire mipsPkg::regAddrT rt,
    input  wire mipsPkg::regAddrT exMemWsel,
    input  wire                   exMemRegWrite,
    input  wire mipsPkg::regAddrT memWbWsel,
    input  wire                   memWbRegWrite,
    output mipsPkg::fwdSelT       fwdA,
    output mipsPkg::fwdSelT       fwdB
);

    // youngest producer wins, r0 never matches
    function automatic mipsPkg::fwdSelT pickSource(input mipsPkg::regAddrT src);
        if (exMemRegWrite && exMemWsel != '0 && exMemWsel == src) begin
            return mipsPkg::fwdMem;
        end else if (memWbRegWrite && memWbWsel != '0 && memWbWsel == src) begin
            return mipsPkg::fwdWb;
        end
        return mipsPkg::fwdNone;
    endfunction

    always_comb begin
        fwdA = pickSource(rs);
        fwdB = pickSource(rt);
    end

endmodule

`default_nettype wire

//--- mipsPipeline.sv
`timescale 1ns/10ps
`default_nettype none

module mipsPipeline (
    input  wire                  clk,
    input  wire                  rst_n,
    output mipsPkg::cacheReqT    icacheReq,
    input  wire                  icacheStall,
    input  wire mipsPkg::wordT   icacheRdata,
    output mipsPkg::cacheReqT    dcacheReq,
    input  wire                  dcacheStall,
    input  wire mipsPkg::wordT   dcacheRdata
);

    mipsPkg::wordT    pc;
    mipsPkg::wordT    pcNext;
    mipsPkg::wordT    pcPlus4;
    mipsPkg::ifIdT    ifId;
    mipsPkg::idExT    idEx;
    mipsPkg::exMemT   exMem;
    mipsPkg::memWbT   memWb;

    mipsPkg::ctrlT    decCtrl;
    logic             jump;
    mipsPkg::wordT    rsData;
    mipsPkg::wordT    rtData;
    mipsPkg::wordT    immExt;
    mipsPkg::regAddrT wselDec;
    mipsPkg::wordT    jumpTarget;

    logic             freeze;
    logic             pcHold;
    logic             ifIdHold;
    logic             ifIdFlush;
    logic             idExBubble;
    logic             exMemFlush;
    logic             branchTaken;

    mipsPkg::fwdSelT  fwdA;
    mipsPkg::fwdSelT  fwdB;
    mipsPkg::wordT    opA;
    mipsPkg::wordT    rtFwd;
    mipsPkg::wordT    opB;
    mipsPkg::wordT    aluResult;
    logic             aluZero;
    mipsPkg::wordT    wbData;

    function automatic mipsPkg::wordT bypassMux(
        input mipsPkg::fwdSelT sel,
        input mipsPkg::wordT   regVal,
        input mipsPkg::wordT   memVal,
        input mipsPkg::wordT   wbVal
    );
        case (sel)
            mipsPkg::fwdMem: return memVal;
            mipsPkg::fwdWb:  return wbVal;
            default:         return regVal;
        endcase
    endfunction

    //////////////////////////////////////////////////////////////////////
    // fetch

    assign pcPlus4 = pc + 32'd4;

    // taken branch beats jump
    always_comb begin
        if (branchTaken) begin
            pcNext = exMem.branchTarget;
        end else if (jump) begin
            pcNext = jumpTarget;
        end else begin
            pcNext = pcPlus4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= '0;
        end else if (!pcHold) begin
            pc <= pcNext;
        end
    end

    // instruction side is read-only
    always_comb begin
        icacheReq.ren   = 1'b1;
        icacheReq.wen   = 1'b0;
        icacheReq.addr  = pc[31:2];
        icacheReq.wdata = '0;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ifId <= '0;
        end else if (!ifIdHold) begin
            if (ifIdFlush) begin
                ifId <= '0;
            end else begin
                ifId.instr   <= icacheRdata;
                ifId.pcPlus4 <= pcPlus4;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // decode

    instrDecoder i_instrDecoder (
        .instr (ifId.instr),
        .ctrl  (decCtrl),
        .jump  (jump)
    );

    registerFile i_registerFile (
        .clk    (clk),
        .rst_n  (rst_n),
        .wen    (memWb.regWrite),
        .waddr  (memWb.wsel),
        .wdata  (wbData),
        .raddrA (ifId.instr[25:21]),
        .raddrB (ifId.instr[20:16]),
        .rdataA (rsData),
        .rdataB (rtData)
    );

    hazardUnit i_hazardUnit (
        .ifId        (ifId),
        .idEx        (idEx),
        .jump        (jump),
        .exBranch    (exMem.branch),
        .exZero      (exMem.zero),
        .icacheStall (icacheStall),
        .dcacheStall (dcacheStall),
        .freeze      (freeze),
        .pcHold      (pcHold),
        .ifIdHold    (ifIdHold),
        .ifIdFlush   (ifIdFlush),
        .idExBubble  (idExBubble),
        .exMemFlush  (exMemFlush),
        .branchTaken (branchTaken)
    );

    assign immExt     = {{16{ifId.instr[15]}}, ifId.instr[15:0]};
    assign wselDec    = decCtrl.regDstRd ? ifId.instr[15:11] : ifId.instr[20:16];
    assign jumpTarget = {ifId.pcPlus4[31:28], ifId.instr[25:0], 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            idEx <= '0;
        end else if (!freeze) begin
            if (idExBubble) begin
                idEx <= '0;
            end else begin
                idEx.ctrl    <= decCtrl;
                idEx.pcPlus4 <= ifId.pcPlus4;
                idEx.rsData  <= rsData;
                idEx.rtData  <= rtData;
                idEx.immExt  <= immExt;
                idEx.rs      <= ifId.instr[25:21];
                idEx.rt      <= ifId.instr[20:16];
                idEx.wsel    <= wselDec;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // execute

    forwardUnit i_forwardUnit (
        .rs            (idEx.rs),
        .rt            (idEx.rt),
        .exMemWsel     (exMem.wsel),
        .exMemRegWrite (exMem.regWrite),
        .memWbWsel     (memWb.wsel),
        .memWbRegWrite (memWb.regWrite),
        .fwdA          (fwdA),
        .fwdB          (fwdB)
    );

    always_comb begin
        opA   = bypassMux(fwdA, idEx.rsData, exMem.aluOut, wbData);
        rtFwd = bypassMux(fwdB, idEx.rtData, exMem.aluOut, wbData);
        opB   = idEx.ctrl.aluSrcImm ? idEx.immExt : rtFwd;
    end

    alu i_alu (
        .aluCtrl (idEx.ctrl.aluCtrl),
        .a       (opA),
        .b       (opB),
        .result  (aluResult),
        .zero    (aluZero)
    );

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exMem <= '0;
        end else if (!freeze) begin
            if (exMemFlush) begin
                exMem <= '0;
            end else begin
                exMem.regWrite     <= idEx.ctrl.regWrite;
                exMem.memRead      <= idEx.ctrl.memRead;
                exMem.memWrite     <= idEx.ctrl.memWrite;
                exMem.branch       <= idEx.ctrl.branch;
                exMem.zero         <= aluZero;
                exMem.aluOut       <= aluResult;
                exMem.storeData    <= rtFwd;
                exMem.branchTarget <= idEx.pcPlus4 + {idEx.immExt[29:0], 2'b00};
                exMem.wsel         <= idEx.wsel;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // memory and writeback

    // held steady by exMem while frozen
    always_comb begin
        dcacheReq.ren   = exMem.memRead;
        dcacheReq.wen   = exMem.memWrite;
        dcacheReq.addr  = exMem.aluOut[31:2];
        dcacheReq.wdata = exMem.storeData;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            memWb <= '0;
        end else if (!freeze) begin
            memWb.regWrite <= exMem.regWrite;
            memWb.memRead  <= exMem.memRead;
            memWb.aluOut   <= exMem.aluOut;
            memWb.loadData <= dcacheRdata;
            memWb.wsel     <= exMem.wsel;
        end
    end

    assign wbData = memWb.memRead ? memWb.loadData : memWb.aluOut;

endmodule

`default_nettype wire

//--- tbCacheModel.sv
`timescale 1ns/10ps
`default_nettype none

module tbCacheModel (
    input  wire                        clk,
    input  wire                        rst_n,
    input  wire                        stallEn,
    input  wire mipsPkg::cacheReqT     icacheReq,
    output logic                       icacheStall,
    output mipsPkg::wordT              icacheRdata,
    input  wire mipsPkg::cacheReqT     dcacheReq,
    output logic                       dcacheStall,
    output mipsPkg::wordT              dcacheRdata
);

    mipsPkg::wordT imem [256];
    mipsPkg::wordT dmem [256];

    integer seed;
    int     iLeft;
    int     dLeft;

    // one stall burst of 0 to 3 cycles, then at least one free cycle
    task automatic stepStall(inout logic stall, inout int left);
        int len;
        if (left > 0) begin
            stall = 1'b1;
            left--;
        end else if (stall) begin
            stall = 1'b0;
        end else begin
            len = $random(seed) & 3;
            if (len > 0) begin
                stall = 1'b1;
                left  = len - 1;
            end
        end
    endtask

    initial begin
        seed        = 99253;
        iLeft       = 0;
        dLeft       = 0;
        icacheStall = 1'b0;
        dcacheStall = 1'b0;
    end

    // both caches answer in the same cycle
    assign icacheRdata = imem[icacheReq.addr[7:0]];
    assign dcacheRdata = dmem[dcacheReq.addr[7:0]];

    always @(posedge clk) begin
        logic enNow;
        // enable taken at the edge, where it is stable
        enNow = stallEn;
        #1;
        if (!enNow) begin
            icacheStall = 1'b0;
            dcacheStall = 1'b0;
            iLeft       = 0;
            dLeft       = 0;
        end else begin
            stepStall(icacheStall, iLeft);
            stepStall(dcacheStall, dLeft);
        end
    end

    // data memory comes up with a pattern of the word address
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int a = 0; a < 256; a++) begin
                dmem[a] <= 32'hC0DE_0000 | (32'(a) * 32'h0000_0111);
            end
        end else if (dcacheReq.wen && !icacheStall && !dcacheStall) begin
            dmem[dcacheReq.addr[7:0]] <= dcacheReq.wdata;
        end
    end

endmodule

`default_nettype wire

//--- tbMipsPipeline.sv
`timescale 1ns/10ps
`default_nettype none

module tbMipsPipeline;

    typedef struct packed {
        mipsPkg::wordAddrT addr;
        mipsPkg::wordT     data;
    } storePairT;

    localparam int          testCount   = 8;
    localparam int          maxProgLen  = 24;
    // worst case per instruction incl. load-use and 4x stall stretch
    localparam int          watchdogCycles = testCount * maxProgLen * 8;
    localparam logic [15:0] markerOffset = 16'h01FC;
    localparam logic [15:0] markerValue  = 16'h05A5;

    logic              clk;
    logic              rst_n;
    logic              stallEn;
    mipsPkg::cacheReqT icacheReq;
    mipsPkg::cacheReqT dcacheReq;
    logic              icacheStall;
    logic              dcacheStall;
    mipsPkg::wordT     icacheRdata;
    mipsPkg::wordT     dcacheRdata;

    storePairT expQ [$];
    string     curName;
    int        pcIdx;
    int        testErrors;
    int        totalErrors;
    int        testsFailed;
    logic      markerSeen;

    mipsPipeline i_mipsPipeline (
        .clk         (clk),
        .rst_n       (rst_n),
        .icacheReq   (icacheReq),
        .icacheStall (icacheStall),
        .icacheRdata (icacheRdata),
        .dcacheReq   (dcacheReq),
        .dcacheStall (dcacheStall),
        .dcacheRdata (dcacheRdata)
    );

    tbCacheModel memModel (
        .clk         (clk),
        .rst_n       (rst_n),
        .stallEn     (stallEn),
        .icacheReq   (icacheReq),
        .icacheStall (icacheStall),
        .icacheRdata (icacheRdata),
        .dcacheReq   (dcacheReq),
        .dcacheStall (dcacheStall),
        .dcacheRdata (dcacheRdata)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // program assembly

    task automatic place(input mipsPkg::wordT instr);
        memModel.imem[pcIdx] = instr;
        pcIdx++;
    endtask

    task automatic rOp(input logic [5:0] fn, input int rd, input int rs, input int rt);
        place({mipsPkg::opRType, 5'(rs), 5'(rt), 5'(rd), 5'd0, fn});
    endtask

    task automatic addImm(input int rt, input int rs, input logic [15:0] imm);
        place({mipsPkg::opAddi, 5'(rs), 5'(rt), imm});
    endtask

    task automatic loadWord(input int rt, input logic [15:0] offset);
        place({mipsPkg::opLw, 5'd0, 5'(rt), offset});
    endtask

    task automatic storeWord(input int rt, input logic [15:0] offset);
        place({mipsPkg::opSw, 5'd0, 5'(rt), offset});
    endtask

    // offset counts words from the slot after the branch
    task automatic branchEq(input int rs, input int rt, input int target);
        place({mipsPkg::opBeq, 5'(rs), 5'(rt), 16'(target - pcIdx - 1)});
    endtask

    task automatic jumpTo(input int target);
        place({mipsPkg::opJ, 26'(target)});
    endtask

    task automatic expectStore(input logic [15:0] offset, input mipsPkg::wordT data);
        storePairT p;
        p.addr = 30'(offset >> 2);
        p.data = data;
        expQ.push_back(p);
    endtask

    // marker store, then spin
    task automatic finishProgram();
        addImm(30, 0, markerValue);
        storeWord(30, markerOffset);
        expectStore(markerOffset, 32'(markerValue));
        jumpTo(pcIdx);
    endtask

    function automatic mipsPkg::wordT patternWord(input int wordIdx);
        return 32'hC0DE_0000 | (32'(wordIdx) * 32'h0000_0111);
    endfunction

    task automatic aluProgram();
        int a, b, c, d, e, f, g, h, m, n;
        a = 7;
        b = a + 7;
        c = a + b;
        d = c - a;
        e = c & d;
        f = d | a;
        g = (d < c) ? 1 : 0;
        h = (c < d) ? 1 : 0;
        m = -3;
        n = (m < a) ? 1 : 0;
        addImm(1, 0, 16'd7);
        addImm(2, 1, 16'd7);
        rOp(mipsPkg::fnAdd, 3, 1, 2);
        // r1 read while its write is in writeback
        rOp(mipsPkg::fnSub, 4, 3, 1);
        rOp(mipsPkg::fnAnd, 5, 3, 4);
        rOp(mipsPkg::fnOr, 6, 4, 1);
        rOp(mipsPkg::fnSlt, 7, 4, 3);
        rOp(mipsPkg::fnSlt, 8, 3, 4);
        addImm(9, 0, 16'hFFFD);
        rOp(mipsPkg::fnSlt, 10, 9, 1);
        storeWord(10, 16'h0100);
        storeWord(9, 16'h0104);
        storeWord(8, 16'h0108);
        storeWord(7, 16'h010C);
        storeWord(6, 16'h0110);
        storeWord(5, 16'h0114);
        storeWord(4, 16'h0118);
        storeWord(3, 16'h011C);
        storeWord(2, 16'h0120);
        expectStore(16'h0100, n);
        expectStore(16'h0104, m);
        expectStore(16'h0108, h);
        expectStore(16'h010C, g);
        expectStore(16'h0110, f);
        expectStore(16'h0114, e);
        expectStore(16'h0118, d);
        expectStore(16'h011C, c);
        expectStore(16'h0120, b);
        finishProgram();
    endtask

    task automatic loadUseProgram();
        addImm(3, 0, 16'd9);
        loadWord(1, 16'h0040);
        rOp(mipsPkg::fnAdd, 2, 1, 3);
        storeWord(2, 16'h0100);
        loadWord(4, 16'h0044);
        storeWord(4, 16'h0104);
        loadWord(5, 16'h0048);
        rOp(mipsPkg::fnSub, 6, 3, 5);
        storeWord(6, 16'h0108);
        expectStore(16'h0100, patternWord(16) + 32'd9);
        expectStore(16'h0104, patternWord(17));
        expectStore(16'h0108, 32'd9 - patternWord(18));
        finishProgram();
    endtask

    task automatic branchProgram();
        addImm(1, 0, 16'd4);
        addImm(2, 0, 16'd4);
        branchEq(1, 2, 7);
        storeWord(1, 16'h0100);
        storeWord(1, 16'h0104);
        storeWord(1, 16'h0108);
        storeWord(1, 16'h010C);
        // index 7 is the taken target
        storeWord(2, 16'h0110);
        addImm(3, 0, 16'd1);
        branchEq(1, 3, 11);
        storeWord(3, 16'h0114);
        expectStore(16'h0110, 32'd4);
        expectStore(16'h0114, 32'd1);
        finishProgram();
    endtask

    task automatic jumpProgram();
        addImm(1, 0, 16'h0033);
        jumpTo(4);
        storeWord(1, 16'h0100);
        storeWord(1, 16'h0104);
        storeWord(1, 16'h0108);
        expectStore(16'h0108, 32'h33);
        finishProgram();
    endtask

    //////////////////////////////////////////////////////////////////////
    // committed data writes against the scoreboard

    always @(posedge clk) begin
        storePairT got;
        storePairT exp;
        if (rst_n && dcacheReq.wen && !icacheStall && !dcacheStall) begin
            got.addr = dcacheReq.addr;
            got.data = dcacheReq.wdata;
            assert (expQ.size() > 0) else begin
                $display("test %s: data write to word %h with no store left to expect",
                         curName, got.addr);
                testErrors++;
            end
            if (expQ.size() > 0) begin
                exp = expQ.pop_front();
                assert (got == exp) else begin
                    $display("FAIL %s: expected %h:%h actual %h:%h", curName,
                             exp.addr, exp.data, got.addr, got.data);
                    testErrors++;
                end
            end
            if (got.addr == 30'(markerOffset >> 2)) begin
                markerSeen = 1'b1;
            end
        end
    end

    task automatic checkResetState();
        assert (!dcacheReq.ren && !dcacheReq.wen) else begin
            $display("test %s: data cache request active during reset", curName);
            testErrors++;
        end
        assert (icacheReq.ren && !icacheReq.wen) else begin
            $display("test %s: instruction cache request is not a plain read", curName);
            testErrors++;
        end
        assert (icacheReq.addr == '0) else begin
            $display("FAIL %s: expected %h actual %h", curName, 30'd0, icacheReq.addr);
            testErrors++;
        end
    endtask

    task automatic runTest(input string name, input int prog, input logic withStalls);
        @(posedge clk);
        #1;
        rst_n      = 1'b0;
        stallEn    = 1'b0;
        curName    = name;
        markerSeen = 1'b0;
        expQ.delete();
        for (int i = 0; i < 256; i++) begin
            memModel.imem[i] = '0;
        end
        pcIdx = 0;
        case (prog)
            0: aluProgram();
            1: loadUseProgram();
            2: branchProgram();
            default: jumpProgram();
        endcase
        repeat (4) @(posedge clk);
        #1;
        checkResetState();
        rst_n   = 1'b1;
        stallEn = withStalls;
        wait (markerSeen);
        repeat (4) @(posedge clk);
        #1;
        assert (expQ.size() == 0) else begin
            $display("test %s: %0d expected stores never happened", name, expQ.size());
            testErrors++;
        end
        if (testErrors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, testErrors);
            testsFailed++;
        end
        totalErrors += testErrors;
        testErrors = 0;
    endtask

    initial begin
        int t;
        t = watchdogCycles;
        repeat (t) @(posedge clk);
        $display("watchdog: run did not finish within %0d cycles", t);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial begin
        rst_n       = 1'b0;
        stallEn     = 1'b0;
        totalErrors = 0;
        testsFailed = 0;
        testErrors  = 0;
        markerSeen  = 1'b0;
        curName     = "init";
        pcIdx       = 0;
        runTest("aluChain", 0, 1'b0);
        runTest("loadUse", 1, 1'b0);
        runTest("branch", 2, 1'b0);
        runTest("jump", 3, 1'b0);
        // same programs, same writes, with both caches stalling
        runTest("aluChainStall", 0, 1'b1);
        runTest("loadUseStall", 1, 1'b1);
        runTest("branchStall", 2, 1'b1);
        runTest("jumpStall", 3, 1'b1);
        $display("tests %0d, passed %0d, failed %0d, errors %0d", testCount,
                 testCount - testsFailed, testsFailed, totalErrors);
        if (totalErrors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
mipsPkg.sv
instrDecoder.sv
registerFile.sv
alu.sv
hazardUnit.sv
forwardUnit.sv
mipsPipeline.sv
tbCacheModel.sv
tbMipsPipeline.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := tbMipsPipeline
FILELIST  := filelist.f
LOG       := sim.log
BIN       := obj_dir/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: compile
	./$(BIN) | tee $(LOG)
	@if grep -q "TESTBENCH FAILED" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "TESTBENCH PASSED" $(LOG); then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir $(LOG)
